// ==== verilog.f ====
hw/mgt_support_pkg.sv
hw/host_cmd_port.sv
hw/lol_supervisor.sv
hw/comma_align_detector.sv
hw/mgt_support_top.sv
tests/mgt_support_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module mgt_support_tb \
    -o mgt_support_sim

./obj_dir/mgt_support_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// ==== tests/mgt_support_tb.sv ====
////////////////////
// testbench for the transceiver support top: clock, reset, watchdog,
// host handshake task and a stimulus table applied in a loop
////////////////////
module mgt_support_tb;

    // one table row, one step of the test
    typedef struct packed {
        mgt_support_pkg::host_op_e      op;         // host command of the row
        logic [2:0]                     wr;         // tx, rx, cpll reset bits
        logic                           lock;       // cpll_lock level
        logic                           done;       // both tx done bits
        logic [1:0]                     kind;       // 0 data, 1 comma, 2 nit, 3 k high
        logic [7:0]                     nwords;     // rx words of that kind
        logic [7:0]                     hold;       // idle cycles after
        logic                           exp_al;     // expected rx_aligned_o
        logic                           exp_lol;    // expected loss_of_lock_o
        logic [2:0]                     exp_rst;    // expected gt_resets_o
        logic                           chk_st;     // check lol_state on a read
        mgt_support_pkg::lol_state_e    exp_st;
    } row_t;

    logic                                       evgRxClkIn;
    logic                                       rst_n_i;
    logic                                       host_req_i;
    mgt_support_pkg::host_cmd_t                 host_cmd_i;
    logic                                       host_ack_o;
    logic [mgt_support_pkg::host_data_w-1:0]    host_rdata_o;
    mgt_support_pkg::gt_status_t                gt_status_i;
    mgt_support_pkg::rx_word_t                  rx_word_i;
    mgt_support_pkg::gt_resets_t                gt_resets_o;
    logic                                       rx_aligned_o;
    logic                                       loss_of_lock_o;

    row_t        rows[$];
    logic [31:0] rnd_state;
    int          errors;
    int          checks;
    logic        table_ready;

    mgt_support_top #(
        .lds_needed    (8),
        .rsts_needed   (2),
        .commas_needed (6)
    ) uut (
        .evgRxClkIn     (evgRxClkIn),
        .rst_n_i        (rst_n_i),
        .host_req_i     (host_req_i),
        .host_cmd_i     (host_cmd_i),
        .host_ack_o     (host_ack_o),
        .host_rdata_o   (host_rdata_o),
        .gt_status_i    (gt_status_i),
        .rx_word_i      (rx_word_i),
        .gt_resets_o    (gt_resets_o),
        .rx_aligned_o   (rx_aligned_o),
        .loss_of_lock_o (loss_of_lock_o)
    );

    always #50 evgRxClkIn = ~evgRxClkIn;        // period 100

    ////////////////////
    // helpers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mgt_support_pkg::rx_word_t make_word(input logic [1:0] kind,
                                                            input logic [15:0] rnd);
        mgt_support_pkg::rx_word_t w;
        w = '{data: rnd, char_is_k: 2'b00, not_in_table: 2'b00};  // plain data, never a comma
        case (kind)
            2'd1: w = '{data: {rnd[15:8], 8'hBC}, char_is_k: 2'b01, not_in_table: 2'b00};
            2'd2: w.not_in_table = 2'b01;               // decode error
            2'd3: w.char_is_k = 2'b10;                  // K on high byte
            default: w = w;
        endcase
        return w;
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Fail %0t: %s", $time, msg);
        end
    endtask

    // one rx word per cycle, each comma followed by a random data word
    task automatic send_words(input logic [1:0] kind, input int n);
        for (int i = 0; i < n; i++) begin
            rnd_state = xorshift(rnd_state);
            rx_word_i = make_word(kind, rnd_state[15:0]);
            @(posedge evgRxClkIn);
            #10;
            if (kind == 2'd1) begin
                rnd_state = xorshift(rnd_state);
                rx_word_i = make_word(2'd0, rnd_state[15:0]);
                @(posedge evgRxClkIn);
                #10;
            end
        end
        rnd_state = xorshift(rnd_state);
        rx_word_i = make_word(2'd0, rnd_state[15:0]);   // back to data
    endtask

    ////////////////////
    // four-phase host transaction
    task automatic host_xfer(input mgt_support_pkg::host_op_e op, input logic [2:0] wr,
                             output logic [31:0] rdata);
        int n;
        host_cmd_i = '{op: op, resets: wr};
        host_req_i = 1'b1;
        n = 0;
        do begin
            @(posedge evgRxClkIn);
            #10;
            n++;
        end while (!host_ack_o && n < 20);
        if (!host_ack_o) begin
            errors++;
            $display("host ack never came for opcode %0d", op);
        end
        rdata = host_rdata_o;
        host_req_i = 1'b0;
        n = 0;
        do begin
            @(posedge evgRxClkIn);
            #10;
            n++;
        end while (host_ack_o && n < 20);
        check(!host_ack_o, "ack did not fall after req fell");
    endtask

    task automatic add_row(input mgt_support_pkg::host_op_e op, input logic [2:0] wr,
                           input logic lock, input logic done, input logic [1:0] kind,
                           input int nwords, input int hold, input logic exp_al,
                           input logic exp_lol, input logic [2:0] exp_rst,
                           input logic chk_st, input mgt_support_pkg::lol_state_e exp_st);
        row_t row;
        row = '{op, wr, lock, done, kind, 8'(nwords), 8'(hold),
                exp_al, exp_lol, exp_rst, chk_st, exp_st};
        rows.push_back(row);
    endtask

    ////////////////////
    // stimulus table
    task automatic build_table;
        // reset control and readback
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b011, 1, 1, 0, 0, 2, 0, 0, 3'b011, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_READ_STATUS, 3'b000, 1, 1, 0, 0, 2, 0, 0, 3'b011, 1,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 1, 0, 0, 2, 0, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        // alignment gained and lost
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 1, 6, 1, 1, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 2, 1, 1, 0, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 1, 5, 1, 0, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 2, 1, 1, 0, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 1, 5, 1, 0, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 1, 1, 1, 1, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);    // sixth in a row
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 3, 1, 1, 0, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 1, 1, 1, 6, 1, 1, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        // loss of lock, two good sequences
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 0, 1, 0, 0, 5, 1, 1, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b100, 1, 1, 0, 0, 2, 1, 1, 3'b100, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 1, 0, 0, 20, 1, 1, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_READ_STATUS, 3'b000, 1, 1, 0, 0, 1, 1, 1, 3'b000, 1,
                mgt_support_pkg::LOL_WAIT_USER_RESET);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b100, 1, 1, 0, 0, 2, 1, 1, 3'b100, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 1, 0, 0, 20, 1, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_READ_STATUS, 3'b000, 1, 1, 0, 0, 1, 1, 0, 3'b000, 1,
                mgt_support_pkg::LOL_CHECK);
        // tx reset at the wrong time restarts the count
        add_row(mgt_support_pkg::OP_NOP, 3'b000, 0, 1, 0, 0, 5, 1, 1, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b100, 1, 1, 0, 0, 2, 1, 1, 3'b100, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 1, 0, 0, 20, 1, 1, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);    // one sequence already counted
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b100, 1, 0, 0, 0, 2, 1, 1, 3'b100, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 0, 0, 0, 20, 1, 1, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_READ_STATUS, 3'b000, 1, 0, 0, 0, 1, 1, 1, 3'b000, 1,
                mgt_support_pkg::LOL_WAIT_RESET_DONE);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b100, 1, 0, 0, 0, 2, 1, 1, 3'b100, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 1, 0, 0, 20, 1, 1, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);    // first of two again
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b100, 1, 1, 0, 0, 2, 1, 1, 3'b100, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_WRITE_RESETS, 3'b000, 1, 1, 0, 0, 20, 1, 0, 3'b000, 0,
                mgt_support_pkg::LOL_CHECK);
        add_row(mgt_support_pkg::OP_READ_STATUS, 3'b000, 1, 1, 0, 0, 1, 1, 0, 3'b000, 1,
                mgt_support_pkg::LOL_CHECK);
    endtask

    ////////////////////
    // watchdog
    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * 40 * 100 + 20000;     // 40 cycles a row plus margin
        #(limit);
        $display("timeout: the run did not finish in %0d time units", limit);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // main sequence
    initial begin
        logic [31:0] rdata;
        row_t        r;
        evgRxClkIn  = 1'b0;
        rst_n_i     = 1'b0;
        host_req_i  = 1'b0;
        host_cmd_i  = '{op: mgt_support_pkg::OP_NOP, resets: 3'b000};
        gt_status_i = 5'b11111;                 // locked, all done
        rnd_state   = 32'ha37e;
        rx_word_i   = make_word(2'd0, 16'h0000);
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge evgRxClkIn);
        #10;
        rst_n_i = 1'b1;
        @(posedge evgRxClkIn);
        #10;
        check(!host_ack_o, "ack high after reset");
        check(gt_resets_o == 3'b000, "resets not low after reset");
        check(!rx_aligned_o, "aligned high after reset");
        check(host_rdata_o == 32'd0, "rdata not zero after reset");
        foreach (rows[i]) begin
            r = rows[i];
            gt_status_i = {r.lock, r.done, r.done, 1'b1, 1'b1};
            if (r.op != mgt_support_pkg::OP_NOP) begin
                host_xfer(r.op, r.wr, rdata);
                if (r.op == mgt_support_pkg::OP_READ_STATUS) begin
                    check(rdata[31:17] == 15'd0, $sformatf("row %0d rdata upper bits set", i));
                    check(rdata[16:14] == r.exp_rst, $sformatf("row %0d read resets", i));
                    check(rdata[13] == r.exp_al, $sformatf("row %0d read aligned", i));
                    check(rdata[12:8] == {r.lock, r.done, r.done, 2'b11},
                          $sformatf("row %0d read gt status", i));
                    check(rdata[7] == r.exp_lol, $sformatf("row %0d read loss of lock", i));
                    if (r.chk_st) begin
                        check(rdata[6:4] == 3'(r.exp_st),
                              $sformatf("row %0d lol_state %0d", i, rdata[6:4]));
                    end
                end
            end
            send_words(r.kind, int'(r.nwords));
            repeat (int'(r.hold)) begin
                @(posedge evgRxClkIn);
                #10;
            end
            check(rx_aligned_o == r.exp_al, $sformatf("row %0d rx_aligned_o", i));
            check(loss_of_lock_o == r.exp_lol, $sformatf("row %0d loss_of_lock_o", i));
            check(gt_resets_o == r.exp_rst, $sformatf("row %0d gt_resets_o", i));
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hw/mgt_support_top.sv ====
////////////////////
// transceiver support top: host port, lock supervisor,
// alignment detector and status word packing
////////////////////
module mgt_support_top #(
    parameter int lds_needed    = 1024,     // synced lock cycles needed
    parameter int rsts_needed   = 2,        // tx reset sequences to clear latch
    parameter int commas_needed = 60        // commas needed for alignment
) (
    input  logic                                    evgRxClkIn,
    input  logic                                    rst_n_i,
    input  logic                                    host_req_i,
    input  mgt_support_pkg::host_cmd_t              host_cmd_i,
    output logic                                    host_ack_o,
    output logic [mgt_support_pkg::host_data_w-1:0] host_rdata_o,
    input  mgt_support_pkg::gt_status_t             gt_status_i,    // async status lines
    input  mgt_support_pkg::rx_word_t               rx_word_i,
    output mgt_support_pkg::gt_resets_t             gt_resets_o,
    output logic                                    rx_aligned_o,
    output logic                                    loss_of_lock_o
);

    mgt_support_pkg::gt_resets_t                gt_resets;
    mgt_support_pkg::reset_status_t             status;
    mgt_support_pkg::lol_state_e                lol_state;
    logic [mgt_support_pkg::rst_count_w-1:0]    rst_count;
    logic                                       loss_of_lock;
    logic                                       rx_aligned;

    ////////////////////
    // host side
    host_cmd_port u_host_cmd_port (
        .evgRxClkIn   (evgRxClkIn),
        .rst_n_i      (rst_n_i),
        .host_req_i   (host_req_i),
        .host_cmd_i   (host_cmd_i),
        .status_i     (status),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .gt_resets_o  (gt_resets)
    );

    ////////////////////
    // pll supervision
    lol_supervisor #(
        .lds_needed  (lds_needed),
        .rsts_needed (rsts_needed)
    ) u_lol_supervisor (
        .evgRxClkIn          (evgRxClkIn),
        .rst_n_i             (rst_n_i),
        .gt_tx_reset_i       (gt_resets.gt_tx_reset),
        .cpll_lock_i         (gt_status_i.cpll_lock),
        .tx_reset_done_i     (gt_status_i.tx_reset_done),
        .tx_fsm_reset_done_i (gt_status_i.tx_fsm_reset_done),
        .loss_of_lock_o      (loss_of_lock),
        .lol_state_o         (lol_state),
        .rst_count_o         (rst_count)
    );

    ////////////////////
    // rx alignment
    comma_align_detector #(
        .commas_needed (commas_needed)
    ) u_comma_align_detector (
        .evgRxClkIn   (evgRxClkIn),
        .rst_n_i      (rst_n_i),
        .rx_word_i    (rx_word_i),
        .rx_aligned_o (rx_aligned)
    );

    // status word for host readback, raw gt status as reported
    assign status = '{resets:       gt_resets,
                      rx_aligned:   rx_aligned,
                      gt_status:    gt_status_i,
                      loss_of_lock: loss_of_lock,
                      lol_state:    lol_state,
                      rst_count:    rst_count};

    assign gt_resets_o    = gt_resets;
    assign rx_aligned_o   = rx_aligned;
    assign loss_of_lock_o = loss_of_lock;

endmodule

// ==== hw/comma_align_detector.sv ====
////////////////////
// receiver alignment from a run of clean comma words
////////////////////
module comma_align_detector #(
    parameter int commas_needed = 60        // consecutive clean commas
) (
    input  logic                        evgRxClkIn,
    input  logic                        rst_n_i,
    input  mgt_support_pkg::rx_word_t   rx_word_i,
    output logic                        rx_aligned_o
);

    localparam int comma_reload = commas_needed - 1;             // runs to -1
    localparam int comma_w      = $clog2(comma_reload + 1) + 1;  // top bit is the flag

    logic [comma_w-1:0] comma_cnt;
    logic               aligned;
    logic               bad_word;
    logic               clean_comma;

    assign aligned = comma_cnt[comma_w-1];

    // decode error on either byte or K on the high byte
    assign bad_word = (rx_word_i.not_in_table != 2'b00) || rx_word_i.char_is_k[1];

    // K28.5 on the low byte
    assign clean_comma = !bad_word && rx_word_i.char_is_k[0]
                         && (rx_word_i.data[7:0] == mgt_support_pkg::comma_char);

    always_ff @(posedge evgRxClkIn) begin
        if (!rst_n_i) begin
            comma_cnt <= comma_w'(comma_reload);
        end else if (bad_word) begin
            comma_cnt <= comma_w'(comma_reload);        // drop alignment, recount
        end else if (!aligned && clean_comma) begin
            comma_cnt <= comma_cnt - comma_w'(1);
        end
        // plain data words leave the count alone
    end

    assign rx_aligned_o = aligned;

    ////////////////////
    // alignment check
    no_rise_after_bad: assert property (
        @(posedge evgRxClkIn) disable iff (!rst_n_i)
        $rose(rx_aligned_o) |-> !$past(bad_word)
    ) else $error("alignment rose right after a bad word");

endmodule

// ==== hw/lol_supervisor.sv ====
////////////////////
// pll loss-of-lock supervision: lock synchronizer, lock-stability
// counter, reset-sequence counter and recovery fsm with loss latch
////////////////////
module lol_supervisor #(
    parameter int lds_needed  = 1024,   // synced lock cycles needed
    parameter int rsts_needed = 2       // full tx reset sequences to clear latch
) (
    input  logic                                        evgRxClkIn,
    input  logic                                        rst_n_i,
    input  logic                                        gt_tx_reset_i,
    input  logic                                        cpll_lock_i,    // async
    input  logic                                        tx_reset_done_i,
    input  logic                                        tx_fsm_reset_done_i,
    output logic                                        loss_of_lock_o,
    output mgt_support_pkg::lol_state_e                 lol_state_o,
    output logic [mgt_support_pkg::rst_count_w-1:0]     rst_count_o
);

    localparam int ld_reload  = lds_needed - 2;             // runs to -1
    localparam int ld_w       = $clog2(ld_reload + 1) + 1;  // extra bit is the flag
    localparam int rst_reload = rsts_needed - 2;
    localparam int rst_w      = mgt_support_pkg::rst_count_w;

    logic                           cpll_lock_m;    // first sync stage
    logic                           cpll_lock_s;    // synced lock
    logic [ld_w-1:0]                ld_cnt;
    logic                           lock_stable;
    logic [rst_w-1:0]               rst_cnt;
    logic                           rsts_done;
    logic                           tx_done;
    logic                           lol_latch;
    mgt_support_pkg::lol_state_e    state;

    assign lock_stable = ld_cnt[ld_w-1];        // set once count passes zero
    assign rsts_done   = rst_cnt[rst_w-1];      // last sequence under way
    assign tx_done     = tx_reset_done_i && tx_fsm_reset_done_i;

    ////////////////////
    // lock synchronizer
    // preset high so a lock already present does not flag a loss at start
    always_ff @(posedge evgRxClkIn) begin
        if (!rst_n_i) begin
            cpll_lock_m <= 1'b1;
            cpll_lock_s <= 1'b1;
        end else begin
            cpll_lock_m <= cpll_lock_i;
            cpll_lock_s <= cpll_lock_m;
        end
    end

    ////////////////////
    // recovery fsm
    always_ff @(posedge evgRxClkIn) begin
        if (!rst_n_i) begin
            state     <= mgt_support_pkg::LOL_CHECK;
            lol_latch <= 1'b0;
            ld_cnt    <= ld_w'(ld_reload);
            rst_cnt   <= rst_w'(rst_reload);
        end else begin
            case (state)
                mgt_support_pkg::LOL_CHECK: begin
                    if (gt_tx_reset_i) begin            // reset at the wrong time
                        rst_cnt <= rst_w'(rst_reload);
                        state   <= mgt_support_pkg::LOL_WAIT_USER_RESET_CLR;
                    end else if (!cpll_lock_s) begin
                        lol_latch <= 1'b1;              // hold until recovered
                        rst_cnt   <= rst_w'(rst_reload);
                        state     <= mgt_support_pkg::LOL_WAIT_USER_RESET;
                    end
                end
                mgt_support_pkg::LOL_WAIT_USER_RESET: begin
                    if (gt_tx_reset_i) begin
                        state <= mgt_support_pkg::LOL_WAIT_USER_RESET_CLR;
                    end
                end
                mgt_support_pkg::LOL_WAIT_USER_RESET_CLR: begin
                    if (!gt_tx_reset_i) begin
                        ld_cnt <= ld_w'(ld_reload);     // start stability window
                        state  <= mgt_support_pkg::LOL_WAIT_CPLL_LOCK;
                    end
                end
                mgt_support_pkg::LOL_WAIT_CPLL_LOCK: begin
                    if (!cpll_lock_s) begin
                        ld_cnt <= ld_w'(ld_reload);     // lock dropped, restart
                    end else if (!lock_stable) begin
                        ld_cnt <= ld_cnt - ld_w'(1);
                    end
                    if (gt_tx_reset_i) begin
                        rst_cnt <= rst_w'(rst_reload);
                        state   <= mgt_support_pkg::LOL_WAIT_USER_RESET_CLR;
                    end else if (lock_stable) begin
                        state <= mgt_support_pkg::LOL_WAIT_RESET_DONE;
                    end
                end
                mgt_support_pkg::LOL_WAIT_RESET_DONE: begin
                    if (gt_tx_reset_i) begin
                        rst_cnt <= rst_w'(rst_reload);
                        state   <= mgt_support_pkg::LOL_WAIT_USER_RESET_CLR;
                    end else if (tx_done) begin
                        if (!rsts_done) begin
                            rst_cnt <= rst_cnt - rst_w'(1);     // one more sequence
                            state   <= mgt_support_pkg::LOL_WAIT_USER_RESET;
                        end else begin
                            lol_latch <= 1'b0;
                            state     <= mgt_support_pkg::LOL_CHECK;
                        end
                    end
                end
                default: begin
                    state <= mgt_support_pkg::LOL_CHECK;
                end
            endcase
        end
    end

    assign loss_of_lock_o = lol_latch;
    assign lol_state_o    = state;
    assign rst_count_o    = rst_cnt;

    ////////////////////
    // supervisor checks
    latch_clear_only_when_done: assert property (
        @(posedge evgRxClkIn) disable iff (!rst_n_i)
        $fell(lol_latch) |->
            (!$past(rst_n_i) || $past(state == mgt_support_pkg::LOL_WAIT_RESET_DONE))
    ) else $error("loss-of-lock latch cleared outside reset-done wait");

    state_legal: assert property (
        @(posedge evgRxClkIn) disable iff (!rst_n_i)
        state inside {mgt_support_pkg::LOL_CHECK,
                      mgt_support_pkg::LOL_WAIT_USER_RESET,
                      mgt_support_pkg::LOL_WAIT_USER_RESET_CLR,
                      mgt_support_pkg::LOL_WAIT_CPLL_LOCK,
                      mgt_support_pkg::LOL_WAIT_RESET_DONE}
    ) else $error("supervisor state out of range");

endmodule

// ==== hw/host_cmd_port.sv ====
////////////////////
// host command port with four-phase req/ack handshake,
// reset-control register and status snapshot
////////////////////
module host_cmd_port (
    input  logic                                      evgRxClkIn,
    input  logic                                      rst_n_i,
    input  logic                                      host_req_i,
    input  mgt_support_pkg::host_cmd_t                host_cmd_i,   // stable while req high
    input  mgt_support_pkg::reset_status_t            status_i,
    output logic                                      host_ack_o,
    output logic [mgt_support_pkg::host_data_w-1:0]   host_rdata_o,
    output mgt_support_pkg::gt_resets_t               gt_resets_o
);

    typedef enum logic {
        HS_IDLE = 1'b0,     // waiting for req
        HS_ACK  = 1'b1      // ack held until req drops
    } hs_state_e;

    hs_state_e                                  hs_state;
    logic [mgt_support_pkg::host_data_w-1:0]    rdata_q;
    mgt_support_pkg::gt_resets_t                resets_q;
    logic                                       accept;

    assign accept = (hs_state == HS_IDLE) && host_req_i;    // new request this edge

    ////////////////////
    // handshake fsm
    always_ff @(posedge evgRxClkIn) begin
        if (!rst_n_i) begin
            hs_state <= HS_IDLE;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (host_req_i) begin
                        hs_state <= HS_ACK;     // ack one cycle after req
                    end
                end
                HS_ACK: begin
                    if (!host_req_i) begin
                        hs_state <= HS_IDLE;    // first edge with req low
                    end
                end
                default: begin
                    hs_state <= HS_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // command decode, snapshot and reset register
    always_ff @(posedge evgRxClkIn) begin
        if (!rst_n_i) begin
            rdata_q  <= '0;
            resets_q <= '0;                     // all transceiver resets released
        end else if (accept) begin
            // snapshot taken before any write lands
            rdata_q <= mgt_support_pkg::host_data_w'(status_i);
            case (host_cmd_i.op)
                mgt_support_pkg::OP_WRITE_RESETS: begin
                    resets_q <= host_cmd_i.resets;
                end
                mgt_support_pkg::OP_READ_STATUS: begin
                    resets_q <= resets_q;       // read only
                end
                default: begin
                    resets_q <= resets_q;       // nop
                end
            endcase
        end
    end

    assign host_ack_o   = (hs_state == HS_ACK);
    assign host_rdata_o = rdata_q;
    assign gt_resets_o  = resets_q;

    ////////////////////
    // handshake checks
    ack_needs_req: assert property (
        @(posedge evgRxClkIn) disable iff (!rst_n_i)
        $rose(host_ack_o) |-> $past(host_req_i)
    ) else $error("ack raised without a pending req");

    // rdata must not move under the host while it samples
    rdata_stable: assert property (
        @(posedge evgRxClkIn) disable iff (!rst_n_i)
        (host_ack_o && $past(host_ack_o)) |-> $stable(host_rdata_o)
    ) else $error("rdata changed while ack high");

endmodule

// ==== hw/mgt_support_pkg.sv ====
////////////////////
// shared types and constants for the transceiver support logic:
// reset/status structs, rx word, supervisor states and host opcodes
////////////////////
package mgt_support_pkg;

    ////////////////////
    // widths and constants
    localparam int host_data_w = 32;            // host read data width
    localparam int rst_count_w = 4;             // reported reset-sequence count
    localparam logic [7:0] comma_char = 8'hBC;  // K28.5

    ////////////////////
    // transceiver side
    typedef struct packed {
        logic gt_tx_reset;          // soft tx reset
        logic gt_rx_reset;          // soft rx reset
        logic cpll_reset;           // channel pll reset
    } gt_resets_t;

    typedef struct packed {
        logic cpll_lock;            // async, synced in supervisor
        logic tx_reset_done;
        logic tx_fsm_reset_done;
        logic rx_reset_done;
        logic rx_fsm_reset_done;
    } gt_status_t;

    typedef struct packed {
        logic [15:0] data;          // two 8b10b-decoded bytes
        logic [1:0]  char_is_k;     // per byte K flag
        logic [1:0]  not_in_table;  // per byte decode error
    } rx_word_t;

    // loss-of-lock recovery states
    typedef enum logic [2:0] {
        LOL_CHECK               = 3'd0,
        LOL_WAIT_USER_RESET     = 3'd1,
        LOL_WAIT_USER_RESET_CLR = 3'd2,
        LOL_WAIT_CPLL_LOCK      = 3'd3,
        LOL_WAIT_RESET_DONE     = 3'd4
    } lol_state_e;

    ////////////////////
    // host side
    typedef enum logic [1:0] {
        OP_NOP          = 2'd0,
        OP_WRITE_RESETS = 2'd1,     // load reset register
        OP_READ_STATUS  = 2'd2      // status snapshot only
    } host_op_e;

    typedef struct packed {
        host_op_e   op;
        gt_resets_t resets;         // used by OP_WRITE_RESETS
    } host_cmd_t;

    // status word, msb first, zero-extended onto host data
    typedef struct packed {
        gt_resets_t             resets;
        logic                   rx_aligned;
        gt_status_t             gt_status;
        logic                   loss_of_lock;
        lol_state_e             lol_state;
        logic [rst_count_w-1:0] rst_count;
    } reset_status_t;

endpackage
